/* common/ctrl_defs.svh */
`ifndef CTRL_DEFS_SVH
`define CTRL_DEFS_SVH

// widths
`define INSTR_W   32
`define OPCODE_W  6
`define FUNCT_W   6
`define ALUOP_W   4
`define PCSEL_W   2

// rt field sits in bits 20:16
`define RT_LSB    16
`define RT_W      5

// opcodes, bits 31:26
`define OP_RTYPE  6'b000000
`define OP_REGIMM 6'b000001
`define OP_J      6'b000010
`define OP_JAL    6'b000011
`define OP_BEQ    6'b000100
`define OP_BNE    6'b000101
`define OP_BLEZ   6'b000110
`define OP_BGTZ   6'b000111
`define OP_ADDI   6'b001000
`define OP_SLTI   6'b001010
`define OP_ANDI   6'b001100
`define OP_ORI    6'b001101
`define OP_XORI   6'b001110
`define OP_MUL    6'b011100
`define OP_LB     6'b100000
`define OP_LH     6'b100001
`define OP_LW     6'b100011
`define OP_SB     6'b101000
`define OP_SH     6'b101001
`define OP_SW     6'b101011

// r-type function codes, bits 5:0
`define FN_SLL    6'b000000
`define FN_SRL    6'b000010
`define FN_JR     6'b001000
`define FN_ADD    6'b100000
`define FN_SUB    6'b100010
`define FN_AND    6'b100100
`define FN_OR     6'b100101
`define FN_XOR    6'b100110
`define FN_NOR    6'b100111
`define FN_SLT    6'b101010

// rt codes under REGIMM
`define RT_BLTZ   5'd0
`define RT_BGEZ   5'd1

`endif

/* common/ctrlPkg.sv */
package ctrlPkg;

  typedef logic [31:0] instrT;
  typedef logic [5:0]  opcodeT;
  typedef logic [5:0]  functT;
  typedef logic [3:0]  aluOpT;
  typedef logic [1:0]  pcSelT;
  typedef logic [1:0]  accessSizeT;
  typedef logic [1:0]  flowClassT;

  // alu operation codes
  localparam aluOpT aluAnd  = 4'd0;
  localparam aluOpT aluAdd  = 4'd1;
  localparam aluOpT aluSub  = 4'd2;
  localparam aluOpT aluSlt  = 4'd3;
  localparam aluOpT aluSll  = 4'd4;
  localparam aluOpT aluMul  = 4'd5;
  localparam aluOpT aluBeq  = 4'd6;
  localparam aluOpT aluBne  = 4'd7;
  localparam aluOpT aluBltz = 4'd8;
  localparam aluOpT aluBgez = 4'd9;
  localparam aluOpT aluOr   = 4'd10;
  localparam aluOpT aluNor  = 4'd11;
  localparam aluOpT aluXor  = 4'd12;
  localparam aluOpT aluSrl  = 4'd13;
  localparam aluOpT aluBlez = 4'd14;
  localparam aluOpT aluBgtz = 4'd15;

  // program counter select
  localparam pcSelT pcSeq    = 2'd0;
  localparam pcSelT pcBranch = 2'd1;
  localparam pcSelT pcReg    = 2'd2; // jr
  localparam pcSelT pcJump   = 2'd3;

  localparam accessSizeT sizeByte = 2'd0;
  localparam accessSizeT sizeHalf = 2'd1;
  localparam accessSizeT sizeWord = 2'd2;

  // decoder to resolver
  localparam flowClassT flowSeq  = 2'd0;
  localparam flowClassT flowCond = 2'd1;
  localparam flowClassT flowReg  = 2'd2;
  localparam flowClassT flowJump = 2'd3;

endpackage

/* controller/instrDecoder.sv */
`include "ctrl_defs.svh"

module instrDecoder import ctrlPkg::*; (
  input  instrT      instr,
  output logic       regDst,
  output aluOpT      aluOp,
  output logic       aluSrc,
  output logic       regWrite,
  output logic       memWrite,
  output logic       memRead,
  output logic       memToReg,
  output logic       jump,
  output logic       jalMux,
  output accessSizeT accessSize,
  output flowClassT  flowClass
);

  opcodeT           opcode;
  functT            funct;
  logic [`RT_W-1:0] rt;
  aluOpT            rAluOp;   // alu code of an r-type function
  logic             rKnown;
  aluOpT            immAluOp; // alu code of an immediate op
  accessSizeT       memSize;

  assign opcode = instr[`INSTR_W-1 -: `OPCODE_W];
  assign funct  = instr[`FUNCT_W-1:0];
  assign rt     = instr[`RT_LSB +: `RT_W];

  // r-type function table, jr is handled in the main table
  always_comb begin
    rKnown = 1'b1;
    case (funct)
      `FN_AND: rAluOp = aluAnd;
      `FN_ADD: rAluOp = aluAdd;
      `FN_SUB: rAluOp = aluSub;
      `FN_SLT: rAluOp = aluSlt;
      `FN_SLL: rAluOp = aluSll;
      `FN_SRL: rAluOp = aluSrl;
      `FN_OR:  rAluOp = aluOr;
      `FN_NOR: rAluOp = aluNor;
      `FN_XOR: rAluOp = aluXor;
      default: begin
        rAluOp = aluAnd;
        rKnown = 1'b0;
      end
    endcase
  end

  // immediate alu code and memory access size, both keyed on opcode
  always_comb begin
    case (opcode)
      `OP_ADDI: immAluOp = aluAdd;
      `OP_SLTI: immAluOp = aluSlt;
      `OP_ORI:  immAluOp = aluOr;
      `OP_XORI: immAluOp = aluXor;
      default:  immAluOp = aluAnd; // andi
    endcase
    case (opcode)
      `OP_LB, `OP_SB: memSize = sizeByte;
      `OP_LH, `OP_SH: memSize = sizeHalf;
      default:        memSize = sizeWord;
    endcase
  end

  always_comb begin
    // start from the no-op word
    regDst     = 1'b0;
    aluOp      = aluAnd;
    aluSrc     = 1'b0;
    regWrite   = 1'b0;
    memWrite   = 1'b0;
    memRead    = 1'b0;
    memToReg   = 1'b0;
    jump       = 1'b0;
    jalMux     = 1'b1;
    accessSize = sizeWord;
    flowClass  = flowSeq;
    case (opcode)
      `OP_RTYPE: begin
        if (funct == `FN_JR) begin
          regDst    = 1'b1;
          memToReg  = 1'b1;
          flowClass = flowReg;
        end else if (rKnown) begin
          regDst   = 1'b1;
          regWrite = 1'b1;
          memToReg = 1'b1;
          aluOp    = rAluOp;
        end
      end
      `OP_MUL: begin
        regDst   = 1'b1;
        regWrite = 1'b1;
        memToReg = 1'b1;
        aluOp    = aluMul;
      end
      `OP_REGIMM: begin
        case (rt)
          `RT_BLTZ: begin
            aluOp     = aluBltz;
            flowClass = flowCond;
          end
          `RT_BGEZ: begin
            aluOp     = aluBgez;
            flowClass = flowCond;
          end
          default: jalMux = 1'b0; // unknown rt
        endcase
      end
      `OP_BEQ: begin
        aluOp     = aluBeq;
        flowClass = flowCond;
      end
      `OP_BNE: begin
        aluOp     = aluBne;
        flowClass = flowCond;
      end
      `OP_BLEZ: begin
        aluOp     = aluBlez;
        flowClass = flowCond;
      end
      `OP_BGTZ: begin
        aluOp     = aluBgtz;
        flowClass = flowCond;
      end
      `OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        aluOp    = immAluOp;
      end
      `OP_LB, `OP_LH, `OP_LW: begin
        regWrite   = 1'b1;
        aluSrc     = 1'b1;
        memRead    = 1'b1;
        aluOp      = aluAdd; // address add
        accessSize = memSize;
      end
      `OP_SB, `OP_SH, `OP_SW: begin
        aluSrc     = 1'b1;
        memWrite   = 1'b1;
        aluOp      = aluAdd;
        accessSize = memSize;
      end
      `OP_J: begin
        jump      = 1'b1;
        flowClass = flowJump;
      end
      `OP_JAL: begin
        jump   = 1'b1;
        jalMux = 1'b0; // pc select stays sequential for jal
      end
      default: jalMux = 1'b0;
    endcase
  end

endmodule

/* controller/branchResolver.sv */
module branchResolver import ctrlPkg::*; (
  input  flowClassT flowClass,
  input  logic      comparator,
  output logic      branchTaken,
  output pcSelT     pcSrc
);

  // comparator result belongs to the instruction being decoded
  always_comb begin
    branchTaken = 1'b0;
    pcSrc       = pcSeq;
    case (flowClass)
      flowCond: begin
        branchTaken = comparator;
        if (comparator) begin
          pcSrc = pcBranch;
        end else begin
          pcSrc = pcSeq; // not taken, fall through
        end
      end
      flowReg:  pcSrc = pcReg;
      flowJump: pcSrc = pcJump;
      default:  pcSrc = pcSeq;
    endcase
  end

endmodule

/* controller/ctrlStageReg.sv */
module ctrlStageReg import ctrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       instrValid,
  input  logic       decRegDst,
  input  aluOpT      decAluOp,
  input  logic       decAluSrc,
  input  logic       decBranchTaken,
  input  logic       decRegWrite,
  input  logic       decMemWrite,
  input  logic       decMemRead,
  input  pcSelT      decPcSrc,
  input  logic       decMemToReg,
  input  logic       decJump,
  input  logic       decJalMux,
  input  accessSizeT decAccessSize,
  output logic       ctrlValid,
  output logic       regDst,
  output aluOpT      aluOp,
  output logic       aluSrc,
  output logic       branchTaken,
  output logic       regWrite,
  output logic       memWrite,
  output logic       memRead,
  output pcSelT      pcSrc,
  output logic       memToReg,
  output logic       jump,
  output logic       jalMux,
  output accessSizeT accessSize
);

  always_ff @(posedge clk) begin
    if (rst || !instrValid) begin
      // bubble, load the no-op word
      ctrlValid   <= 1'b0;
      regDst      <= 1'b0;
      aluOp       <= aluAnd;
      aluSrc      <= 1'b0;
      branchTaken <= 1'b0;
      regWrite    <= 1'b0;
      memWrite    <= 1'b0;
      memRead     <= 1'b0;
      pcSrc       <= pcSeq;
      memToReg    <= 1'b0;
      jump        <= 1'b0;
      jalMux      <= 1'b1;
      accessSize  <= sizeWord;
    end else begin
      ctrlValid   <= 1'b1;
      regDst      <= decRegDst;
      aluOp       <= decAluOp;
      aluSrc      <= decAluSrc;
      branchTaken <= decBranchTaken;
      regWrite    <= decRegWrite;
      memWrite    <= decMemWrite;
      memRead     <= decMemRead;
      pcSrc       <= decPcSrc;
      memToReg    <= decMemToReg;
      jump        <= decJump;
      jalMux      <= decJalMux;
      accessSize  <= decAccessSize;
    end
  end

endmodule

/* controller/controller.sv */
module controller import ctrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  instrT      instr,
  input  logic       instrValid,
  input  logic       comparator,
  output logic       ctrlValid,
  output logic       regDst,
  output aluOpT      aluOp,
  output logic       aluSrc,
  output logic       branchTaken,
  output logic       regWrite,
  output logic       memWrite,
  output logic       memRead,
  output pcSelT      pcSrc,
  output logic       memToReg,
  output logic       jump,
  output logic       jalMux,
  output accessSizeT accessSize
);

  // decode stage outputs, before the pipeline register
  logic       decRegDst;
  aluOpT      decAluOp;
  logic       decAluSrc;
  logic       decRegWrite;
  logic       decMemWrite;
  logic       decMemRead;
  logic       decMemToReg;
  logic       decJump;
  logic       decJalMux;
  accessSizeT decAccessSize;
  flowClassT  decFlowClass;
  logic       decBranchTaken;
  pcSelT      decPcSrc;

  instrDecoder u_decoder (
    .instr      (instr),
    .regDst     (decRegDst),
    .aluOp      (decAluOp),
    .aluSrc     (decAluSrc),
    .regWrite   (decRegWrite),
    .memWrite   (decMemWrite),
    .memRead    (decMemRead),
    .memToReg   (decMemToReg),
    .jump       (decJump),
    .jalMux     (decJalMux),
    .accessSize (decAccessSize),
    .flowClass  (decFlowClass)
  );

  branchResolver u_resolver (
    .flowClass   (decFlowClass),
    .comparator  (comparator),  // same cycle as instr
    .branchTaken (decBranchTaken),
    .pcSrc       (decPcSrc)
  );

  ctrlStageReg u_stageReg (
    .clk            (clk),
    .rst            (rst),
    .instrValid     (instrValid),
    .decRegDst      (decRegDst),
    .decAluOp       (decAluOp),
    .decAluSrc      (decAluSrc),
    .decBranchTaken (decBranchTaken),
    .decRegWrite    (decRegWrite),
    .decMemWrite    (decMemWrite),
    .decMemRead     (decMemRead),
    .decPcSrc       (decPcSrc),
    .decMemToReg    (decMemToReg),
    .decJump        (decJump),
    .decJalMux      (decJalMux),
    .decAccessSize  (decAccessSize),
    .ctrlValid      (ctrlValid),
    .regDst         (regDst),
    .aluOp          (aluOp),
    .aluSrc         (aluSrc),
    .branchTaken    (branchTaken),
    .regWrite       (regWrite),
    .memWrite       (memWrite),
    .memRead        (memRead),
    .pcSrc          (pcSrc),
    .memToReg       (memToReg),
    .jump           (jump),
    .jalMux         (jalMux),
    .accessSize     (accessSize)
  );

endmodule

/* bench/controller_assertions.sv */
`include "ctrl_defs.svh"

module controllerAssertions import ctrlPkg::*; (
  input logic       clk,
  input logic       rst,
  input instrT      instr,
  input logic       instrValid,
  input logic       comparator,
  input logic       ctrlValid,
  input logic       regDst,
  input aluOpT      aluOp,
  input logic       aluSrc,
  input logic       branchTaken,
  input logic       regWrite,
  input logic       memWrite,
  input logic       memRead,
  input pcSelT      pcSrc,
  input logic       memToReg,
  input logic       jump,
  input logic       jalMux,
  input accessSizeT accessSize
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [16:0] noopWord = {1'b0, aluAnd, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, pcSeq,
                                      1'b0, 1'b0, 1'b1, sizeWord};

  int         failCount; // read by the testbench at the end
  instrT      prevInstr;
  logic       prevValid;
  logic       prevCmp;
  logic       prevRst;
  logic       seenRst;   // checks start once reset has been seen
  logic       live;
  opcodeT     op;
  functT      fn;
  logic [4:0] rt;
  logic       isRAlu, isJr, isMul, isImm, isLoad, isStore, isBranch, isJ, isJal;
  logic       badOp, badRtype;
  logic       expTaken;
  aluOpT      expAluOp;
  pcSelT      expPcSrc;
  accessSizeT expSize;
  logic [16:0] actWord;
  logic [16:0] expWord;

  always_ff @(posedge clk) begin
    prevInstr <= instr;
    prevValid <= instrValid;
    prevCmp   <= comparator;
    prevRst   <= rst;
    if (rst) begin
      seenRst <= 1'b1;
    end
  end

  assign live = seenRst && !prevRst && prevValid;
  assign op   = prevInstr[`INSTR_W-1 -: `OPCODE_W];
  assign fn   = prevInstr[`FUNCT_W-1:0];
  assign rt   = prevInstr[`RT_LSB +: `RT_W];

  // classify the instruction sampled one edge back
  always_comb begin
    isRAlu   = (op == `OP_RTYPE) && (fn inside {`FN_AND, `FN_ADD, `FN_SUB, `FN_SLT, `FN_SLL,
                                               `FN_SRL, `FN_OR, `FN_NOR, `FN_XOR});
    isJr     = (op == `OP_RTYPE) && (fn == `FN_JR);
    isMul    = op == `OP_MUL;
    isImm    = op inside {`OP_ADDI, `OP_SLTI, `OP_ANDI, `OP_ORI, `OP_XORI};
    isLoad   = op inside {`OP_LB, `OP_LH, `OP_LW};
    isStore  = op inside {`OP_SB, `OP_SH, `OP_SW};
    isBranch = (op inside {`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ})
               || ((op == `OP_REGIMM) && (rt inside {`RT_BLTZ, `RT_BGEZ}));
    isJ      = op == `OP_J;
    isJal    = op == `OP_JAL;
    badRtype = (op == `OP_RTYPE) && !isRAlu && !isJr;
    badOp    = !((op == `OP_RTYPE) || isMul || isImm || isLoad || isStore || isBranch
                 || isJ || isJal);
  end

  // expected alu code from the code table
  always_comb begin
    expAluOp = aluAnd;
    if (isRAlu) begin
      case (fn)
        `FN_ADD: expAluOp = aluAdd;
        `FN_SUB: expAluOp = aluSub;
        `FN_SLT: expAluOp = aluSlt;
        `FN_SLL: expAluOp = aluSll;
        `FN_SRL: expAluOp = aluSrl;
        `FN_OR:  expAluOp = aluOr;
        `FN_NOR: expAluOp = aluNor;
        `FN_XOR: expAluOp = aluXor;
        default: expAluOp = aluAnd;
      endcase
    end else if (isLoad || isStore || op == `OP_ADDI) begin
      expAluOp = aluAdd;
    end else begin
      case (op)
        `OP_MUL:    expAluOp = aluMul;
        `OP_SLTI:   expAluOp = aluSlt;
        `OP_ORI:    expAluOp = aluOr;
        `OP_XORI:   expAluOp = aluXor;
        `OP_BEQ:    expAluOp = aluBeq;
        `OP_BNE:    expAluOp = aluBne;
        `OP_BLEZ:   expAluOp = aluBlez;
        `OP_BGTZ:   expAluOp = aluBgtz;
        `OP_REGIMM: expAluOp = (rt == `RT_BGEZ) ? aluBgez : ((rt == `RT_BLTZ) ? aluBltz : aluAnd);
        default:    expAluOp = aluAnd;
      endcase
    end
  end

  always_comb begin
    expTaken = isBranch && prevCmp;
    if (isJr) begin
      expPcSrc = pcReg;
    end else if (isJ) begin
      expPcSrc = pcJump;
    end else if (expTaken) begin
      expPcSrc = pcBranch;
    end else begin
      expPcSrc = pcSeq;
    end
    if (op == `OP_LB || op == `OP_SB) begin
      expSize = sizeByte;
    end else if (op == `OP_LH || op == `OP_SH) begin
      expSize = sizeHalf;
    end else begin
      expSize = sizeWord;
    end
  end

  assign actWord = {regDst, aluOp, aluSrc, branchTaken, regWrite, memWrite, memRead, pcSrc,
                    memToReg, jump, jalMux, accessSize};
  assign expWord = {isRAlu || isJr || isMul, expAluOp, isImm || isLoad || isStore, expTaken,
                    isRAlu || isMul || isImm || isLoad, isStore, isLoad, expPcSrc,
                    isRAlu || isJr || isMul || isImm, isJ || isJal, !(isJal || badOp), expSize};

  resetQuiet: assert property (@(posedge clk) seenRst && prevRst |->
      {ctrlValid, regWrite, memWrite, memRead, jump, branchTaken, pcSrc} == 8'h00)
    else begin
      failCount++;
      $error("FAILED ctrlValid/regWrite/memWrite/memRead/jump/branchTaken/pcSrc got %h expected %h",
             {ctrlValid, regWrite, memWrite, memRead, jump, branchTaken, pcSrc}, 8'h00);
    end

  validFollows: assert property (@(posedge clk) seenRst && !prevRst |-> ctrlValid == prevValid)
    else begin
      failCount++;
      $error("FAILED ctrlValid got %h expected %h", ctrlValid, prevValid);
    end

  bubbleNoop: assert property (@(posedge clk) seenRst && !prevRst && !prevValid |->
      actWord == noopWord)
    else begin
      failCount++;
      $error("FAILED control word got %h expected %h", actWord, noopWord);
    end

  aluDecode: assert property (@(posedge clk) live && (isRAlu || isJr || isMul || isImm) |->
      {aluOp, regDst, aluSrc, regWrite, memToReg} == {expWord[15:12], expWord[16], expWord[11],
                                                     expWord[9], expWord[4]})
    else begin
      failCount++;
      $error("FAILED aluOp/regDst/aluSrc/regWrite/memToReg got %h expected %h",
             {aluOp, regDst, aluSrc, regWrite, memToReg},
             {expWord[15:12], expWord[16], expWord[11], expWord[9], expWord[4]});
    end

  memDecode: assert property (@(posedge clk) live && (isLoad || isStore) |->
      {memRead, memWrite, aluSrc, regWrite, aluOp, accessSize}
      == {expWord[7], expWord[8], expWord[11], expWord[9], expWord[15:12], expWord[1:0]})
    else begin
      failCount++;
      $error("FAILED memRead/memWrite/aluSrc/regWrite/aluOp/accessSize got %h expected %h",
             {memRead, memWrite, aluSrc, regWrite, aluOp, accessSize},
             {expWord[7], expWord[8], expWord[11], expWord[9], expWord[15:12], expWord[1:0]});
    end

  flowDecode: assert property (@(posedge clk) live && (isBranch || isJr || isJ || isJal) |->
      {branchTaken, pcSrc, jump, jalMux} == {expWord[10], expWord[6:5], expWord[3:2]})
    else begin
      failCount++;
      $error("FAILED branchTaken/pcSrc/jump/jalMux got %h expected %h",
             {branchTaken, pcSrc, jump, jalMux}, {expWord[10], expWord[6:5], expWord[3:2]});
    end

  unknownNoop: assert property (@(posedge clk) live && (badOp || badRtype) |->
      actWord == expWord)
    else begin
      failCount++;
      $error("FAILED control word got %h expected %h", actWord, expWord);
    end

endmodule

bind controller controllerAssertions u_checks (
  .clk         (clk),
  .rst         (rst),
  .instr       (instr),
  .instrValid  (instrValid),
  .comparator  (comparator),
  .ctrlValid   (ctrlValid),
  .regDst      (regDst),
  .aluOp       (aluOp),
  .aluSrc      (aluSrc),
  .branchTaken (branchTaken),
  .regWrite    (regWrite),
  .memWrite    (memWrite),
  .memRead     (memRead),
  .pcSrc       (pcSrc),
  .memToReg    (memToReg),
  .jump        (jump),
  .jalMux      (jalMux),
  .accessSize  (accessSize)
);

/* bench/tbController.sv */
module tbController import ctrlPkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int cycleLimit = 500; // 8 reset, ~64 directed, 300 random, plus margin

  logic       clk;
  logic       rst;
  instrT      instr;
  logic       instrValid;
  logic       comparator;
  logic       ctrlValid;
  logic       regDst;
  aluOpT      aluOp;
  logic       aluSrc;
  logic       branchTaken;
  logic       regWrite;
  logic       memWrite;
  logic       memRead;
  pcSelT      pcSrc;
  logic       memToReg;
  logic       jump;
  logic       jalMux;
  accessSizeT accessSize;
  int         cycles;
  int         failures;

  // every defined opcode, r-type first and regimm second
  opcodeT opList [20] = '{6'h00, 6'h01, 6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08,
                          6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h1c, 6'h20, 6'h21, 6'h23, 6'h28,
                          6'h29, 6'h2b};
  // sll srl jr add sub and or xor nor slt
  functT fnList [10] = '{6'h00, 6'h02, 6'h08, 6'h20, 6'h22, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a};

  controller u_controller (
    .clk         (clk),
    .rst         (rst),
    .instr       (instr),
    .instrValid  (instrValid),
    .comparator  (comparator),
    .ctrlValid   (ctrlValid),
    .regDst      (regDst),
    .aluOp       (aluOp),
    .aluSrc      (aluSrc),
    .branchTaken (branchTaken),
    .regWrite    (regWrite),
    .memWrite    (memWrite),
    .memRead     (memRead),
    .pcSrc       (pcSrc),
    .memToReg    (memToReg),
    .jump        (jump),
    .jalMux      (jalMux),
    .accessSize  (accessSize)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic drive(instrT word, logic valid, logic cmp);
    @(posedge clk);
    instr      <= word;
    instrValid <= valid;
    comparator <= cmp;
  endtask

  // rs, rd and shamt bits are filled at random
  function automatic instrT buildInstr(opcodeT op, logic [4:0] rt, functT fn);
    logic [31:0] fill;
    fill = $urandom;
    return {op, fill[4:0], rt, fill[14:5], fn};
  endfunction

  function automatic instrT randomDefined();
    logic [31:0] fill;
    opcodeT      op;
    functT       fn;
    logic [4:0]  rt;
    int          k;
    fill = $urandom;
    k    = $urandom_range(19);
    op   = opList[k];
    k    = $urandom_range(9);
    fn   = (op == 6'h00) ? fnList[k] : fill[5:0];
    rt   = (op == 6'h01) ? {4'd0, fill[6]} : fill[11:7];
    return buildInstr(op, rt, fn);
  endfunction

  task automatic directedWalk();
    instrT word;
    for (int i = 0; i < 20; i++) begin
      if (opList[i] == 6'h00) begin
        for (int f = 0; f < 10; f++) begin
          word = buildInstr(6'h00, 5'd3, fnList[f]);
          drive(word, 1'b1, 1'b0);
          drive(word, 1'b1, 1'b1);
        end
      end else if (opList[i] == 6'h01) begin
        for (int r = 0; r < 2; r++) begin
          word = buildInstr(6'h01, r[4:0], 6'h15); // bltz then bgez
          drive(word, 1'b1, 1'b0);
          drive(word, 1'b1, 1'b1);
        end
      end else begin
        word = buildInstr(opList[i], 5'd9, 6'h11);
        drive(word, 1'b1, 1'b0);
        drive(word, 1'b1, 1'b1);
      end
    end
    drive(buildInstr(6'h3f, 5'd2, 6'h00), 1'b1, 1'b1); // unknown opcode
    drive(buildInstr(6'h00, 5'd2, 6'h3f), 1'b1, 1'b1); // unknown function
    drive(buildInstr(6'h01, 5'd3, 6'h00), 1'b1, 1'b1); // unknown rt
  endtask

  task automatic randomPhase(int count);
    instrT       word;
    logic [31:0] pick;
    for (int n = 0; n < count; n++) begin
      pick = $urandom;
      if (pick[0]) begin
        word = $urandom;
      end else begin
        word = randomDefined();
      end
      drive(word, pick[1], pick[2]);
    end
  endtask

  initial begin
    rst        = 1'b1;
    instr      = '0;
    instrValid = 1'b0;
    comparator = 1'b0;
    void'($urandom(32'h3b995025));
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    directedWalk();
    randomPhase(300);
    drive('0, 1'b0, 1'b0); // bubble so the last word is checked
    repeat (2) @(posedge clk);
    @(negedge clk);
    failures = u_controller.u_checks.failCount;
    $display("closing count: %0d assertion failures", failures);
    if (failures == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("run did not finish within %0d cycles", cycleLimit);
      $display("closing count: %0d assertion failures, 1 timeout",
               u_controller.u_checks.failCount);
      $display("Simulation failed");
      $finish;
    end
  end

endmodule

/* list.f */
+incdir+common
common/ctrlPkg.sv
controller/instrDecoder.sv
controller/branchResolver.sv
controller/ctrlStageReg.sv
controller/controller.sv
bench/controller_assertions.sv
bench/tbController.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tbController
FILELIST  = list.f
RUNARGS   = +verilator+error+limit+100000
PASSMSG   = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP) $(RUNARGS) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf obj_dir
